// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - source/decode_pkg.sv
  - source/gpr_file.sv
  - source/csr_file.sv
  - source/decode_unit.sv
  - source/branch_unit.sv
  - source/decode_stage.sv
  - target: test
    files:
      - tests/tb_decode_stage.sv

// ==== source/branch_unit.sv ====
// redirect is only taken in the fire cycle; ecall and mret take priority over jumps and branches
`default_nettype none

module branch_unit import decode_pkg::*; (
  input  wire xlen_t i_rs1data,
  input  wire xlen_t i_rs2data,
  input  wire pc_t   i_pc,
  input  wire xlen_t i_imm,
  input  wire ctrl_t i_ctrl,
  input  wire xlen_t i_mtvec,
  input  wire xlen_t i_mepc,
  input  wire logic  i_fire,
  output redirect_t  o_redirect
);

  logic cond;
  logic hit;
  pc_t  target;

  always_comb begin
    case (i_ctrl.brfunc)
      3'b000:  cond = (i_rs1data == i_rs2data);
      3'b001:  cond = (i_rs1data != i_rs2data);
      3'b100:  cond = ($signed(i_rs1data) <  $signed(i_rs2data));
      3'b101:  cond = ($signed(i_rs1data) >= $signed(i_rs2data));
      3'b110:  cond = (i_rs1data <  i_rs2data);
      3'b111:  cond = (i_rs1data >= i_rs2data);
      default: cond = 1'b0;
    endcase
  end

  always_comb begin
    hit    = 1'b1;
    target = i_pc + i_imm; // jal and taken branches
    if (i_ctrl.ecall) begin
      target = i_mtvec;
    end else if (i_ctrl.mret) begin
      target = i_mepc;
    end else if (i_ctrl.jalr) begin
      target = (i_rs1data + i_imm) & ~64'd1;
    end else if (!i_ctrl.jal) begin
      hit = i_ctrl.bren && cond;
    end
  end

  assign o_redirect = '{taken: i_fire && hit, target: target};

endmodule

`default_nettype wire

// ==== source/csr_file.sv ====
// five machine CSRs only, others read as zero; ecall update wins over a same-cycle writeback
`default_nettype none

module csr_file import decode_pkg::*; (
  input  wire logic      i_clk,
  input  wire logic      i_reset,
  input  wire logic      i_ren,
  input  wire csr_addr_t i_raddr,
  output xlen_t          o_rdata,
  input  wire logic      i_wen,
  input  wire csr_addr_t i_waddr,
  input  wire xlen_t     i_wdata,
  input  wire logic      i_ecall,
  input  wire pc_t       i_epc,
  output xlen_t          o_mtvec,
  output xlen_t          o_mepc
);

  xlen_t mstatus;
  xlen_t mtvec;
  xlen_t mepc;
  xlen_t mcause;
  xlen_t mscratch;

  always_comb begin
    o_rdata = '0;
    if (i_ren) begin
      case (i_raddr)
        CSR_MSTATUS:  o_rdata = mstatus;
        CSR_MTVEC:    o_rdata = mtvec;
        CSR_MEPC:     o_rdata = mepc;
        CSR_MCAUSE:   o_rdata = mcause;
        CSR_MSCRATCH: o_rdata = mscratch;
        default:      o_rdata = '0;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      mstatus  <= '0;
      mtvec    <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mscratch <= '0;
    end else begin
      if (i_wen) begin
        case (i_waddr)
          CSR_MSTATUS:  mstatus  <= i_wdata;
          CSR_MTVEC:    mtvec    <= i_wdata;
          CSR_MEPC:     mepc     <= i_wdata;
          CSR_MCAUSE:   mcause   <= i_wdata;
          CSR_MSCRATCH: mscratch <= i_wdata;
          default: ;
        endcase
      end
      if (i_ecall) begin // last assignment takes precedence
        mepc   <= i_epc;
        mcause <= CAUSE_ECALL_M;
      end
    end
  end

  assign o_mtvec = mtvec;
  assign o_mepc  = mepc;

endmodule

`default_nettype wire

// ==== source/decode_pkg.sv ====
// shared RV64I/Zicsr decode types; machine mode only, CSR address 0 doubles as "no CSR"
`default_nettype none

package decode_pkg;

  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int GPR_ADDR_W = 5;
  localparam int CSR_ADDR_W = 12;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [XLEN-1:0]       pc_t;
  typedef logic [INST_W-1:0]     inst_t;
  typedef logic [GPR_ADDR_W-1:0] gpr_addr_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  // machine CSRs
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;

  localparam xlen_t CAUSE_ECALL_M = 64'd11;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_IMM32  = 7'b0011011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_REG32  = 7'b0111011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
  } alu_op_e;

  typedef enum logic       {SRC1_RS1, SRC1_PC} src1_sel_e;
  typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR, SRC2_CSR} src2_sel_e;
  typedef enum logic [2:0] {CSR_OP_NONE, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_op_e;

  typedef struct packed {
    logic      bren;
    logic [2:0] brfunc;    // funct3 of the branch
    logic      jal;
    logic      jalr;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    logic      word_cut;   // *W ops, sign-extend low 32 bits
    alu_op_e   alu_op;
    logic      gpr_wen;
    logic      mem_ren;
    logic      mem_wen;
    logic [2:0] mem_op;    // funct3 of load/store
    logic      csr_ren;
    logic      csr_wen;
    csr_op_e   csr_op;
    logic      csr_inst;   // old csr value goes to rd
    logic      ebreak;
    logic      ecall;
    logic      mret;
    logic      illegal;
  } ctrl_t;

  typedef struct packed {
    inst_t inst;
    pc_t   pc;
  } fetch_pkt_t;

  typedef struct packed {
    logic      gpr_wen;
    gpr_addr_t gpr_waddr;
    xlen_t     gpr_wdata;
    logic      csr_wen;
    csr_addr_t csr_waddr;
    xlen_t     csr_wdata;
  } wb_pkt_t;

  typedef struct packed {
    gpr_addr_t gpr_rd;
    csr_addr_t csr_rd;
  } busy_dst_t;

  typedef struct packed {
    xlen_t     rs1data;
    xlen_t     rs2data;
    xlen_t     csrdata;
    xlen_t     imm;
    pc_t       pc;
    gpr_addr_t rd;
    csr_addr_t csr;
    ctrl_t     ctrl;
  } issue_pkt_t;

  typedef struct packed {
    logic taken;
    pc_t  target;
  } redirect_t;

endpackage

`default_nettype wire

// ==== source/decode_stage.sv ====
// no forwarding: any busy rs1/rs2/csr match stalls; payload register is not reset
`default_nettype none

module decode_stage import decode_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  wire logic       i_clk,
  input  wire logic       i_reset,
  input  wire logic       i_fetch_valid,
  input  wire fetch_pkt_t i_fetch,
  output logic            o_allowin,
  output logic            o_issue_valid,
  output issue_pkt_t      o_issue,
  input  wire logic       i_es_allowin,
  output redirect_t       o_redirect,
  input  wire wb_pkt_t    i_wb,
  input  wire busy_dst_t  i_es_dst,
  input  wire busy_dst_t  i_ms_dst,
  input  wire busy_dst_t  i_ws_dst
);

  logic       ds_valid;
  fetch_pkt_t ds_pkt;
  logic       ready_go;
  logic       fire;

  gpr_addr_t  rs1;
  gpr_addr_t  rs2;
  gpr_addr_t  rd;
  xlen_t      imm;
  csr_addr_t  csr;
  ctrl_t      ctrl;
  xlen_t      rs1data;
  xlen_t      rs2data;
  xlen_t      csrdata;
  xlen_t      mtvec;
  xlen_t      mepc;

  function automatic logic dst_conflict(input busy_dst_t d, input gpr_addr_t r1,
                                        input gpr_addr_t r2, input csr_addr_t c);
    return ((d.gpr_rd != '0) && ((d.gpr_rd == r1) || (d.gpr_rd == r2))) ||
           ((d.csr_rd != '0) && (d.csr_rd == c));
  endfunction

  // interlock against es/ms/ws
  assign ready_go = !(dst_conflict(i_es_dst, rs1, rs2, csr) ||
                      dst_conflict(i_ms_dst, rs1, rs2, csr) ||
                      dst_conflict(i_ws_dst, rs1, rs2, csr));

  assign o_allowin     = !ds_valid || (ready_go && i_es_allowin);
  assign o_issue_valid = ds_valid && ready_go;
  assign fire          = o_issue_valid && i_es_allowin;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (o_allowin) begin
      ds_valid <= i_fetch_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fetch_valid && o_allowin) begin
      ds_pkt <= i_fetch;
    end
  end

  decode_unit u_decode (
    .i_inst (ds_pkt.inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (rd),
    .o_imm  (imm),
    .o_csr  (csr),
    .o_ctrl (ctrl)
  );

  gpr_file #(
    .NUM_REGS (NUM_REGS)
  ) u_gpr (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .o_rdata1 (rs1data),
    .i_raddr2 (rs2),
    .o_rdata2 (rs2data),
    .i_wen    (i_wb.gpr_wen),
    .i_waddr  (i_wb.gpr_waddr),
    .i_wdata  (i_wb.gpr_wdata)
  );

  csr_file u_csr (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_ren   (ctrl.csr_ren),
    .i_raddr (csr),
    .o_rdata (csrdata),
    .i_wen   (i_wb.csr_wen),
    .i_waddr (i_wb.csr_waddr),
    .i_wdata (i_wb.csr_wdata),
    .i_ecall (fire && ctrl.ecall), // trap state set once, at issue
    .i_epc   (ds_pkt.pc),
    .o_mtvec (mtvec),
    .o_mepc  (mepc)
  );

  branch_unit u_branch (
    .i_rs1data  (rs1data),
    .i_rs2data  (rs2data),
    .i_pc       (ds_pkt.pc),
    .i_imm      (imm),
    .i_ctrl     (ctrl),
    .i_mtvec    (mtvec),
    .i_mepc     (mepc),
    .i_fire     (fire),
    .o_redirect (o_redirect)
  );

  assign o_issue = '{
    rs1data: rs1data,
    rs2data: rs2data,
    csrdata: csrdata,
    imm:     imm,
    pc:      ds_pkt.pc,
    rd:      rd,
    csr:     csr,
    ctrl:    ctrl
  };

endmodule

`default_nettype wire

// ==== source/decode_unit.sv ====
// RV64I + Zicsr + ecall/ebreak/mret; unused register indices read as x0, csr imm forms put zimm in imm
`default_nettype none

module decode_unit import decode_pkg::*; (
  input  wire inst_t i_inst,
  output gpr_addr_t  o_rs1,
  output gpr_addr_t  o_rs2,
  output gpr_addr_t  o_rd,
  output xlen_t      o_imm,
  output csr_addr_t  o_csr,
  output ctrl_t      o_ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;
  logic       use_rs1;
  logic       use_rs2;
  logic       use_rd;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  xlen_t      imm_z;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
  assign imm_z = {59'b0, i_inst[19:15]};  // csr*i operand

  function automatic alu_op_e alu_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    o_ctrl  = '0;
    o_imm   = '0;
    o_csr   = '0;
    legal   = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rd  = 1'b0;
    case (opcode)
      OP_LUI: begin
        legal = 1'b1; use_rd = 1'b1; o_imm = imm_u;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.alu_op   = ALU_PASSB;
        o_ctrl.gpr_wen  = 1'b1;
      end
      OP_AUIPC: begin
        legal = 1'b1; use_rd = 1'b1; o_imm = imm_u;
        o_ctrl.src1_sel = SRC1_PC;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
      end
      OP_JAL, OP_JALR: begin // rd gets pc + 4
        legal   = (opcode == OP_JAL) || (funct3 == 3'b000);
        use_rs1 = (opcode == OP_JALR);
        use_rd  = 1'b1;
        o_imm   = (opcode == OP_JAL) ? imm_j : imm_i;
        o_ctrl.src1_sel = SRC1_PC;
        o_ctrl.src2_sel = SRC2_FOUR;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.jal      = (opcode == OP_JAL);
        o_ctrl.jalr     = (opcode == OP_JALR);
      end
      OP_BRANCH: begin
        legal = (funct3[2:1] != 2'b01); use_rs1 = 1'b1; use_rs2 = 1'b1; o_imm = imm_b;
        o_ctrl.bren   = 1'b1;
        o_ctrl.brfunc = funct3;
      end
      OP_LOAD: begin
        legal = (funct3 != 3'b111); use_rs1 = 1'b1; use_rd = 1'b1; o_imm = imm_i;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.mem_ren  = 1'b1;
        o_ctrl.mem_op   = funct3;
      end
      OP_STORE: begin
        legal = !funct3[2]; use_rs1 = 1'b1; use_rs2 = 1'b1; o_imm = imm_s;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.mem_wen  = 1'b1;
        o_ctrl.mem_op   = funct3;
      end
      OP_IMM, OP_IMM32: begin
        case (funct3)
          3'b001:  legal = (opcode == OP_IMM) ? (funct7[6:1] == '0) : (funct7 == '0);
          3'b101:  legal = (opcode == OP_IMM) ? (funct7[6:1] inside {6'b000000, 6'b010000})
                                              : (funct7 inside {7'b0000000, 7'b0100000});
          3'b000:  legal = 1'b1;
          default: legal = (opcode == OP_IMM); // no slti/xori etc. in the W group
        endcase
        use_rs1 = 1'b1; use_rd = 1'b1; o_imm = imm_i;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.alu_op   = alu_of(funct3, (funct3 == 3'b101) && i_inst[30]);
        o_ctrl.word_cut = (opcode == OP_IMM32);
        o_ctrl.gpr_wen  = 1'b1;
      end
      OP_REG, OP_REG32: begin
        legal = (funct7 == '0) ||
                ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
        if (opcode == OP_REG32) legal = legal && (funct3 inside {3'b000, 3'b001, 3'b101});
        use_rs1 = 1'b1; use_rs2 = 1'b1; use_rd = 1'b1;
        o_ctrl.alu_op   = alu_of(funct3, i_inst[30]);
        o_ctrl.word_cut = (opcode == OP_REG32);
        o_ctrl.gpr_wen  = 1'b1;
      end
      OP_SYSTEM: begin
        if (funct3 == 3'b000) begin
          case (i_inst)
            32'h0000_0073: begin legal = 1'b1; o_ctrl.ecall = 1'b1; o_csr = CSR_MTVEC; end
            32'h0010_0073: begin legal = 1'b1; o_ctrl.ebreak = 1'b1; end
            32'h3020_0073: begin legal = 1'b1; o_ctrl.mret = 1'b1; o_csr = CSR_MEPC; end
            default: ;
          endcase
        end else if (funct3 != 3'b100) begin
          legal = 1'b1; use_rs1 = !funct3[2]; use_rd = 1'b1;
          o_imm = funct3[2] ? imm_z : '0;
          o_csr = i_inst[31:20];
          o_ctrl.src2_sel = SRC2_CSR;
          o_ctrl.alu_op   = ALU_PASSB;
          o_ctrl.gpr_wen  = 1'b1;
          o_ctrl.csr_ren  = 1'b1;
          o_ctrl.csr_inst = 1'b1;
          o_ctrl.csr_wen  = (funct3[1:0] == 2'b01) || (i_inst[19:15] != '0); // csrrs/c x0: no write
          case (funct3[1:0])
            2'b01:   o_ctrl.csr_op = CSR_OP_WRITE;
            2'b10:   o_ctrl.csr_op = CSR_OP_SET;
            default: o_ctrl.csr_op = CSR_OP_CLEAR;
          endcase
        end
      end
      default: ;
    endcase
    if (!legal) begin
      o_ctrl         = '0;
      o_ctrl.illegal = 1'b1;
      o_imm          = '0;
      o_csr          = '0;
      use_rs1        = 1'b0;
      use_rs2        = 1'b0;
      use_rd         = 1'b0;
    end
  end

  assign o_rs1 = use_rs1 ? i_inst[19:15] : '0;
  assign o_rs2 = use_rs2 ? i_inst[24:20] : '0;
  assign o_rd  = use_rd  ? i_inst[11:7]  : '0;

endmodule

`default_nettype wire

// ==== source/gpr_file.sv ====
// no reset on the array, registers must be written before they are read; x0 is hardwired zero
`default_nettype none

module gpr_file import decode_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  wire logic      i_clk,
  input  wire gpr_addr_t i_raddr1,
  output xlen_t          o_rdata1,
  input  wire gpr_addr_t i_raddr2,
  output xlen_t          o_rdata2,
  input  wire logic      i_wen,
  input  wire gpr_addr_t i_waddr,
  input  wire xlen_t     i_wdata
);

  xlen_t regs [NUM_REGS];

  // async reads
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin // x0 writes dropped
      regs[i_waddr] <= i_wdata;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
source/decode_pkg.sv
source/gpr_file.sv
source/csr_file.sv
source/decode_unit.sv
source/branch_unit.sv
source/decode_stage.sv
tests/tb_decode_stage.sv

// ==== tests/tb_decode_stage.sv ====
// drives decode_stage through decode, interlock, back-pressure, branch and CSR cases; no forwarding assumed
`default_nettype none

module tb_decode_stage;
  import decode_pkg::*;

  localparam int N_RAND      = 60;
  localparam int STIM_CYCLES = 32 * 3 + N_RAND * 5 + 200;
  localparam int LIMIT       = 4 * STIM_CYCLES;

  logic       i_clk;
  logic       i_reset;
  logic       i_fetch_valid;
  fetch_pkt_t i_fetch;
  logic       o_allowin;
  logic       o_issue_valid;
  issue_pkt_t o_issue;
  logic       i_es_allowin;
  redirect_t  o_redirect;
  wb_pkt_t    i_wb;
  busy_dst_t  i_es_dst;
  busy_dst_t  i_ms_dst;
  busy_dst_t  i_ws_dst;

  logic [31:0] rng_state = 32'h45a5;
  xlen_t       gpr_m [32];   // model register file
  xlen_t       m_mstatus, m_mtvec, m_mepc, m_mcause, m_mscratch;
  fetch_pkt_t  exp_q [$];    // accepted, not yet issued
  int          errors = 0;
  int          issued = 0;
  int          cycles = 0;
  logic        fire_s;
  fetch_pkt_t  held;
  issue_pkt_t  exp_issue;
  issue_pkt_t  first_issue;
  redirect_t   exp_redir;

  decode_stage #(.NUM_REGS(32)) decode_stage_inst (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_fetch_valid(i_fetch_valid), .i_fetch(i_fetch), .o_allowin(o_allowin),
    .o_issue_valid(o_issue_valid), .o_issue(o_issue), .i_es_allowin(i_es_allowin),
    .o_redirect(o_redirect), .i_wb(i_wb),
    .i_es_dst(i_es_dst), .i_ms_dst(i_ms_dst), .i_ws_dst(i_ws_dst)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic xlen_t csr_model(input csr_addr_t a);
    case (a)
      CSR_MSTATUS:  return m_mstatus;
      CSR_MTVEC:    return m_mtvec;
      CSR_MEPC:     return m_mepc;
      CSR_MCAUSE:   return m_mcause;
      CSR_MSCRATCH: return m_mscratch;
      default:      return '0;
    endcase
  endfunction

  function automatic alu_op_e alu_ref(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0: return alt ? ALU_SUB : ALU_ADD;
      3'd1: return ALU_SLL;
      3'd2: return ALU_SLT;
      3'd3: return ALU_SLTU;
      3'd4: return ALU_XOR;
      3'd5: return alt ? ALU_SRA : ALU_SRL;
      3'd6: return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // expected issue packet and redirect, straight from the ISA rules
  function automatic void ref_decode(input inst_t in, input pc_t pc,
                                     output issue_pkt_t e, output redirect_t r);
    logic [2:0] f3;
    logic       u1, u2, ud, cond;
    xlen_t      a, b;
    f3 = in[14:12];
    u1 = 1'b0;
    u2 = 1'b0;
    ud = 1'b0;
    e = '0;
    r = '0;
    e.pc = pc;
    case (in[6:0])
      OP_LUI, OP_AUIPC: begin
        ud = 1'b1;
        e.imm = {{32{in[31]}}, in[31:12], 12'b0};
        e.ctrl.src2_sel = SRC2_IMM;
        e.ctrl.gpr_wen = 1'b1;
        if (in[6:0] == OP_LUI) e.ctrl.alu_op = ALU_PASSB;
        else e.ctrl.src1_sel = SRC1_PC;
      end
      OP_JAL, OP_JALR: begin
        ud = 1'b1;
        u1 = (in[6:0] == OP_JALR);
        e.imm = u1 ? {{52{in[31]}}, in[31:20]}
                   : {{43{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
        e.ctrl.src1_sel = SRC1_PC;
        e.ctrl.src2_sel = SRC2_FOUR;
        e.ctrl.gpr_wen = 1'b1;
        e.ctrl.jal = !u1;
        e.ctrl.jalr = u1;
      end
      OP_BRANCH: begin
        u1 = 1'b1;
        u2 = 1'b1;
        e.imm = {{51{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
        e.ctrl.bren = 1'b1;
        e.ctrl.brfunc = f3;
      end
      OP_LOAD, OP_STORE: begin
        u1 = 1'b1;
        ud = (in[6:0] == OP_LOAD);
        u2 = !ud;
        e.imm = ud ? {{52{in[31]}}, in[31:20]} : {{52{in[31]}}, in[31:25], in[11:7]};
        e.ctrl.src2_sel = SRC2_IMM;
        e.ctrl.gpr_wen = ud;
        e.ctrl.mem_ren = ud;
        e.ctrl.mem_wen = !ud;
        e.ctrl.mem_op = f3;
      end
      OP_IMM, OP_IMM32, OP_REG, OP_REG32: begin
        u1 = 1'b1;
        ud = 1'b1;
        u2 = (in[6:0] == OP_REG) || (in[6:0] == OP_REG32);
        if (!u2) e.imm = {{52{in[31]}}, in[31:20]};
        e.ctrl.src2_sel = u2 ? SRC2_RS2 : SRC2_IMM;
        e.ctrl.alu_op = alu_ref(f3, (u2 || f3 == 3'd5) && in[30]);
        e.ctrl.word_cut = (in[6:0] == OP_IMM32) || (in[6:0] == OP_REG32);
        e.ctrl.gpr_wen = 1'b1;
      end
      OP_SYSTEM: begin
        if (in == 32'h0000_0073) begin
          e.ctrl.ecall = 1'b1;
          e.csr = CSR_MTVEC;
        end else if (in == 32'h3020_0073) begin
          e.ctrl.mret = 1'b1;
          e.csr = CSR_MEPC;
        end else begin // csrrw / csrrs only
          u1 = 1'b1;
          ud = 1'b1;
          e.csr = in[31:20];
          e.csrdata = csr_model(in[31:20]);
          e.ctrl.src2_sel = SRC2_CSR;
          e.ctrl.alu_op = ALU_PASSB;
          e.ctrl.gpr_wen = 1'b1;
          e.ctrl.csr_ren = 1'b1;
          e.ctrl.csr_inst = 1'b1;
          e.ctrl.csr_wen = (f3 == 3'b001) || (in[19:15] != 5'd0);
          e.ctrl.csr_op = (f3 == 3'b001) ? CSR_OP_WRITE : CSR_OP_SET;
        end
      end
      default: e.ctrl.illegal = 1'b1;
    endcase
    e.rd = ud ? in[11:7] : '0;
    a = u1 ? gpr_m[in[19:15]] : '0;
    b = u2 ? gpr_m[in[24:20]] : '0;
    e.rs1data = a;
    e.rs2data = b;
    case (f3)
      3'd0: cond = (a == b);
      3'd1: cond = (a != b);
      3'd4: cond = ($signed(a) < $signed(b));
      3'd5: cond = ($signed(a) >= $signed(b));
      3'd6: cond = (a < b);
      default: cond = (a >= b);
    endcase
    r.taken = e.ctrl.ecall || e.ctrl.mret || e.ctrl.jal || e.ctrl.jalr ||
              (e.ctrl.bren && cond);
    if (e.ctrl.ecall) r.target = m_mtvec;
    else if (e.ctrl.mret) r.target = m_mepc;
    else if (e.ctrl.jalr) r.target = (a + e.imm) & ~64'd1;
    else r.target = pc + e.imm;
  endfunction

  task automatic check_issue(input issue_pkt_t got, input issue_pkt_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: o_issue got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_redirect(input redirect_t got, input redirect_t exp);
    if (got.taken !== exp.taken || (exp.taken && got.target !== exp.target)) begin
      errors++;
      $display("Error at %0t: o_redirect got %h expected %h", $time, got, exp);
    end
  endtask

  // compare at the falling edge, inputs only move on the rising one
  always @(negedge i_clk) begin
    if (!i_reset) begin
      fire_s = o_issue_valid && i_es_allowin;
      if (fire_s) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Error at %0t: an instruction issued that was never accepted", $time);
        end else begin
          held = exp_q.pop_front();
          ref_decode(held.inst, held.pc, exp_issue, exp_redir);
          check_issue(o_issue, exp_issue);
          check_redirect(o_redirect, exp_redir);
          if (exp_issue.ctrl.ecall) begin // takes effect at this fire edge
            m_mepc = held.pc;
            m_mcause = 64'd11;
          end
          issued++;
        end
      end else if (o_redirect.taken) begin
        errors++;
        $display("Error at %0t: redirect raised outside a fire cycle", $time);
      end
      if (i_fetch_valid && o_allowin) exp_q.push_back(i_fetch);
    end
  end

  task automatic send(input inst_t in, input pc_t pc);
    @(posedge i_clk);
    i_fetch_valid <= 1'b1;
    i_fetch <= '{inst: in, pc: pc};
    @(negedge i_clk);
    while (!o_allowin) @(negedge i_clk);
    @(posedge i_clk);
    i_fetch_valid <= 1'b0;
  endtask

  task automatic wb_gpr(input gpr_addr_t a, input xlen_t d);
    @(posedge i_clk);
    i_wb <= '{gpr_wen: 1'b1, gpr_waddr: a, gpr_wdata: d, default: '0};
    @(posedge i_clk);
    i_wb <= '0;
    if (a != 5'd0) gpr_m[a] = d; // x0 stays zero
  endtask

  task automatic wb_csr(input csr_addr_t a, input xlen_t d);
    @(posedge i_clk);
    i_wb <= '{csr_wen: 1'b1, csr_waddr: a, csr_wdata: d, default: '0};
    @(posedge i_clk);
    i_wb <= '0;
    case (a)
      CSR_MSTATUS:  m_mstatus = d;
      CSR_MTVEC:    m_mtvec = d;
      CSR_MEPC:     m_mepc = d;
      CSR_MCAUSE:   m_mcause = d;
      CSR_MSCRATCH: m_mscratch = d;
      default: ;
    endcase
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(posedge i_clk);
  endtask

  function automatic inst_t rand_inst(input int kind);
    logic [31:0] w;
    logic [2:0]  f3;
    logic [6:0]  f7;
    csr_addr_t   csrs [6];
    logic [2:0]  brf [6];
    csrs = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MSCRATCH, 12'h7c0};
    brf = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    w = xorshift();
    f3 = w[14:12];
    f7 = ((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? 7'h20 : 7'h00;
    case (kind)
      0: return {w[31:7], OP_LUI};
      1: return {w[31:7], OP_AUIPC};
      2: return {w[31:15], (f3 == 3'd7) ? 3'd3 : f3, w[11:7], OP_LOAD};
      3: return {w[31:15], 1'b0, w[13:12], w[11:7], OP_STORE};
      4: begin
        if (f3 == 3'd1) return {6'b0, w[25:15], f3, w[11:7], OP_IMM};
        if (f3 == 3'd5) return {1'b0, w[30], 4'b0, w[25:15], f3, w[11:7], OP_IMM};
        return {w[31:15], f3, w[11:7], OP_IMM};
      end
      5: return {w[31:15], 3'd0, w[11:7], OP_IMM32};
      6: return {f7, w[24:15], f3, w[11:7], OP_REG};
      7: return {w[30] ? 7'h20 : 7'h00, w[24:15], 3'd0, w[11:7], OP_REG32};
      8: return {w[31:25], w[0] ? w[19:15] : w[24:20], w[19:15], brf[w[29:27] % 6],
                 w[11:7], OP_BRANCH};
      9: return {w[31:7], OP_JAL};
      10: return {w[31:15], 3'd0, w[11:7], OP_JALR};
      11: return {csrs[w[29:27] % 6], w[19:15], 3'b010, w[11:7], OP_SYSTEM};
      default: return {w[31:7], 7'b0000000}; // illegal opcode
    endcase
  endfunction

  initial begin
    while (cycles < LIMIT) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", LIMIT);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    i_reset <= 1'b1;
    i_fetch_valid <= 1'b0;
    i_fetch <= '0;
    i_es_allowin <= 1'b1;
    i_wb <= '0;
    i_es_dst <= '0;
    i_ms_dst <= '0;
    i_ws_dst <= '0;
    gpr_m[0] = '0;
    {m_mstatus, m_mtvec, m_mepc, m_mcause, m_mscratch} = '0;
    repeat (2) @(posedge i_clk);
    i_reset <= 1'b0;
    for (int i = 0; i < 32; i++) wb_gpr(i[4:0], {xorshift(), xorshift()});

    // random decode with writebacks in between
    for (int n = 0; n < N_RAND; n++) begin
      send(rand_inst(xorshift() % 13), {xorshift(), xorshift() & ~32'd3});
      if (n % 4 == 3) begin
        drain();
        wb_gpr(5'(xorshift() % 32), {xorshift(), xorshift()});
      end
    end
    drain();

    // x0 after a write to it
    wb_gpr(5'd0, 64'hdead_beef_0bad_cafe);
    send({7'd0, 5'd0, 5'd0, 3'd0, 5'd9, OP_REG}, 64'h100);
    drain();

    // interlock on rs1, rs2 and CSR
    for (int k = 0; k < 3; k++) begin
      @(posedge i_clk);
      if (k == 0) i_es_dst <= '{gpr_rd: 5'd5, csr_rd: '0};
      if (k == 1) i_ms_dst <= '{gpr_rd: 5'd6, csr_rd: '0};
      if (k == 2) i_ws_dst <= '{gpr_rd: '0, csr_rd: CSR_MSCRATCH};
      if (k < 2) send({7'd0, 5'd6, 5'd5, 3'd0, 5'd7, OP_REG}, 64'h200);
      else send({CSR_MSCRATCH, 5'd0, 3'b010, 5'd8, OP_SYSTEM}, 64'h204);
      repeat (4) begin
        @(negedge i_clk);
        if (o_issue_valid || o_allowin) begin
          errors++;
          $display("Error at %0t: a busy destination did not stall the stage", $time);
        end
      end
      @(posedge i_clk);
      i_es_dst <= '0;
      i_ms_dst <= '0;
      i_ws_dst <= '0;
      drain();
    end
    send({12'd1, 5'd0, 3'd0, 5'd3, OP_IMM}, 64'h208);
    @(negedge i_clk);
    if (!o_issue_valid) begin
      errors++;
      $display("Error at %0t: an instruction stalled with no busy destination", $time);
    end
    drain();

    // back-pressure holds the packet and blocks fetch
    @(posedge i_clk);
    i_es_allowin <= 1'b0;
    send(rand_inst(6), 64'h300);
    @(posedge i_clk);
    i_fetch_valid <= 1'b1;
    i_fetch <= '{inst: rand_inst(4), pc: 64'h304};
    @(negedge i_clk);
    first_issue = o_issue;
    repeat (5) begin
      @(negedge i_clk);
      if (o_issue !== first_issue || o_allowin) begin
        errors++;
        $display("Error at %0t: issue packet moved or fetch accepted under back-pressure",
                 $time);
      end
    end
    @(posedge i_clk);
    i_es_allowin <= 1'b1;
    @(negedge i_clk);
    while (!o_allowin) @(negedge i_clk);
    @(posedge i_clk);
    i_fetch_valid <= 1'b0;
    send(rand_inst(0), 64'h308);
    drain();

    // branches of each kind, jal, jalr
    for (int n = 0; n < 24; n++) begin
      send(rand_inst(8 + (n % 3)), {xorshift(), xorshift() & ~32'd3});
    end
    drain();

    // CSR readback, ecall, mret
    wb_csr(CSR_MTVEC, 64'h8000_1000);
    wb_csr(CSR_MSCRATCH, {xorshift(), xorshift()});
    send({CSR_MSCRATCH, 5'd0, 3'b010, 5'd4, OP_SYSTEM}, 64'h400);
    send({CSR_MTVEC, 5'd0, 3'b010, 5'd4, OP_SYSTEM}, 64'h404);
    send(32'h0000_0073, 64'h408);
    send({CSR_MEPC, 5'd0, 3'b010, 5'd4, OP_SYSTEM}, 64'h8000_1000);
    send({CSR_MCAUSE, 5'd0, 3'b010, 5'd4, OP_SYSTEM}, 64'h8000_1004);
    send(32'h3020_0073, 64'h8000_1008);
    drain();

    repeat (3) @(posedge i_clk);
    $display("issued %0d instructions, %0d errors", issued, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
